// File: rtl/tcpq_pkg.sv
// ==================================================
// tcpq package
// packet record layout, FSM encodings, register map
// and the field widths shared by the transmit queue
// ==================================================
package tcpq_pkg;

  localparam int SEQ_W   = 32; // tcp sequence number
  localparam int LEN_W   = 16; // packet length in bytes
  localparam int CS_W    = 32; // raw sum of 16-bit words, not folded
  localparam int TIMER_W = 32; // retransmit timer, counts scanner visits
  localparam int tries_w = 8;  // retransmit attempts

  // one entry of the packet information RAM
  typedef struct packed {
    logic               present; // unacked, payload still held
    logic [CS_W-1:0]    chsum;
    logic [SEQ_W-1:0]   start;   // seq of first byte
    logic [SEQ_W-1:0]   stop;    // seq after last byte = expected ack
    logic [LEN_W-1:0]   length;
    logic [TIMER_W-1:0] timer;
    logic [tries_w-1:0] tries;
  } pkt_info_t;

  typedef enum logic [2:0] {
    scan_s,  // look at the record under the pointer
    read_s,  // evaluate ack and timer
    check_s, // write back, maybe raise a request
    send_s,  // hold tx_req until tx_ack
    next_s,  // step pointer, release freed bytes
    wait_s   // RAM read latency
  } scan_state_e;

  typedef enum logic {
    idle_s, // no open packet
    pend_s  // bytes collected, waiting for a close condition
  } pack_state_e;

  typedef enum logic [1:0] {
    cfg_isn     = 2'd0,
    cfg_rem_ack = 2'd1,
    cfg_ctrl    = 2'd2  // bit 0 connected
  } cfg_addr_e;

endpackage

// File: rtl/tcpq_tcb_regs.sv
// ==================================================
// tcpq connection registers
// isn, remote ack and connected flag, plus the queue
// clear pulse on reset or connection change
// ==================================================
module tcpq_tcb_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         cfg_we,
  input  tcpq_pkg::cfg_addr_e          cfg_addr,
  input  logic [31:0]                  cfg_wdata,
  output logic [tcpq_pkg::SEQ_W-1:0]   isn,
  output logic [tcpq_pkg::SEQ_W-1:0]   rem_ack,
  output logic                         connected,
  output logic                         q_clr
);

  logic conn_wr; // flag as written, connected follows a clock later
  logic rst_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      isn       <= '0;
      rem_ack   <= '0;
      conn_wr   <= 1'b0;
      connected <= 1'b0;
      rst_q     <= 1'b1;
    end else begin
      rst_q     <= 1'b0;
      connected <= conn_wr;
      if (cfg_we) begin
        case (cfg_addr)
          tcpq_pkg::cfg_isn:     isn     <= cfg_wdata;
          tcpq_pkg::cfg_rem_ack: rem_ack <= cfg_wdata;
          tcpq_pkg::cfg_ctrl:    conn_wr <= cfg_wdata[0];
          default: ;
        endcase
      end
    end
  end

  // the queue is wiped while connected still shows the old value,
  // so cts never opens on stale pointers
  assign q_clr = rst_q || (conn_wr != connected);

endmodule

// File: rtl/tcpq_payload_ram.sv
// ==================================================
// tcpq payload RAM
// raw byte store addressed by sequence number, full
// flag from next seq against released ack
// ==================================================
module tcpq_payload_ram #(
  parameter int RAM_DEPTH = 10
) (
  input  logic                       clk,
  input  logic                       q_clr,
  input  logic [tcpq_pkg::SEQ_W-1:0] isn,
  input  logic                       wr_v,
  input  logic [7:0]                 wr_d,
  input  logic [tcpq_pkg::SEQ_W-1:0] wr_seq,
  input  logic [tcpq_pkg::SEQ_W-1:0] release_ack,
  input  logic [tcpq_pkg::SEQ_W-1:0] rd_addr,
  output logic [7:0]                 rd_data,
  output logic                       data_full
);

  localparam logic [tcpq_pkg::SEQ_W-1:0] HIGH_WATER = (1 << RAM_DEPTH) - 1;

  logic [7:0]                 mem [2**RAM_DEPTH];
  logic [tcpq_pkg::SEQ_W-1:0] rel_q;    // oldest byte still needed
  logic [tcpq_pkg::SEQ_W-1:0] prev_ack;
  logic [tcpq_pkg::SEQ_W-1:0] used;
  logic                       settle;   // ignore the scanner's reload after a clear

  always_ff @(posedge clk) begin
    if (wr_v) mem[wr_seq[RAM_DEPTH-1:0]] <= wr_d; // low seq bits are the address
    rd_data <= mem[rd_addr[RAM_DEPTH-1:0]];
  end

  always_ff @(posedge clk) begin
    prev_ack <= release_ack;
    if (q_clr) begin
      rel_q  <= isn; // nothing sent yet
      settle <= 1'b1;
    end else begin
      settle <= 1'b0;
      if (!settle && release_ack != prev_ack) rel_q <= release_ack; // a packet was freed
    end
  end

  assign used      = wr_seq - rel_q;
  assign data_full = (used >= HIGH_WATER); // one byte of margin

endmodule

// File: rtl/tcpq_info_ram.sv
// ==================================================
// tcpq packet info RAM
// record store, add port for the packer and a
// registered update port for the scanner
// ==================================================
module tcpq_info_ram #(
  parameter int PACKET_DEPTH = 3
) (
  input  logic                    clk,
  input  logic                    add_we,
  input  logic [PACKET_DEPTH-1:0] add_addr,
  input  tcpq_pkg::pkt_info_t     add_rec,
  input  logic                    upd_we,
  input  logic [PACKET_DEPTH-1:0] upd_addr,
  input  tcpq_pkg::pkt_info_t     upd_rec,
  output tcpq_pkg::pkt_info_t     upd_q
);

  tcpq_pkg::pkt_info_t mem [2**PACKET_DEPTH];

  initial begin
    for (int i = 0; i < 2**PACKET_DEPTH; i++) mem[i] = '0; // no packet present
  end

  always @(posedge clk) begin
    if (add_we) mem[add_addr] <= add_rec; // write only
  end

  always @(posedge clk) begin
    if (upd_we) begin
      mem[upd_addr] <= upd_rec;
      upd_q         <= upd_rec; // write-through
    end else begin
      upd_q <= mem[upd_addr];
    end
  end

endmodule

// File: rtl/tcpq_packer.sv
// ==================================================
// tcpq packer
// counts bytes, sums big-endian word pairs and adds
// a record when the open packet closes
// ==================================================
module tcpq_packer #(
  parameter int MAX_PAYLOAD_LEN  = 1400,
  parameter int WAIT_TICKS       = 20,
  parameter int RETRANSMIT_TICKS = 1000000,
  parameter int PACKET_DEPTH     = 3
) (
  input  logic                       clk,
  input  logic                       q_clr,
  input  logic [tcpq_pkg::SEQ_W-1:0] isn,
  input  logic                       in_v,
  input  logic [7:0]                 in_d,
  input  logic                       snd,
  input  logic                       data_full,
  input  logic [PACKET_DEPTH:0]      free_ptr,
  output logic                       add_we,
  output logic [PACKET_DEPTH-1:0]    add_addr,
  output tcpq_pkg::pkt_info_t        add_rec,
  output logic [tcpq_pkg::SEQ_W-1:0] next_seq,
  output logic                       slots_full,
  output logic                       writing
);

  tcpq_pkg::pack_state_e           state;
  logic [tcpq_pkg::LEN_W-1:0]      cnt;     // bytes in the open packet
  logic [$clog2(WAIT_TICKS+1)-1:0] idle;    // cycles since the last byte
  logic [tcpq_pkg::CS_W-1:0]       chsum;
  logic [7:0]                      hi_byte; // upper half of the current word
  logic [PACKET_DEPTH:0]           add_ptr;
  logic [PACKET_DEPTH:0]           used;
  logic                            pend;
  logic                            close;

  assign pend  = (state == tcpq_pkg::pend_s);
  assign close = pend && ((32'(idle) == WAIT_TICKS && !in_v) ||
                          32'(cnt) == MAX_PAYLOAD_LEN || data_full || snd);

  assign writing  = close || add_we; // a record write is due or under way
  assign add_addr = add_ptr[PACKET_DEPTH-1:0];
  // open packet and the record in flight both hold a slot
  assign used = add_ptr - free_ptr + (PACKET_DEPTH+1)'(add_we) + (PACKET_DEPTH+1)'(pend);
  assign slots_full = (used == (PACKET_DEPTH+1)'(2**PACKET_DEPTH));

  always_ff @(posedge clk) begin
    if (q_clr) begin
      state    <= tcpq_pkg::idle_s;
      cnt      <= '0;
      idle     <= '0;
      chsum    <= '0;
      next_seq <= isn;
      add_ptr  <= '0;
      add_we   <= 1'b0;
    end else begin
      add_we <= close; // record lands one cycle after the close
      if (add_we) add_ptr <= add_ptr + 1'b1;
      if (in_v) next_seq <= next_seq + 1'b1;
      if (close || !pend) begin
        // packet boundary, a byte here opens the next packet
        idle  <= '0;
        chsum <= '0;
        cnt   <= tcpq_pkg::LEN_W'(in_v);
        state <= in_v ? tcpq_pkg::pend_s : tcpq_pkg::idle_s;
        if (in_v) hi_byte <= in_d;
      end else begin
        idle <= in_v ? '0 : idle + 1'b1;
        if (in_v) begin
          cnt <= cnt + 1'b1;
          if (cnt[0]) chsum <= chsum + 32'({hi_byte, in_d}); // low byte completes a word
          else        hi_byte <= in_d;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (close) begin
      add_rec.present <= 1'b1;
      add_rec.chsum   <= cnt[0] ? chsum + 32'({hi_byte, 8'h00}) : chsum; // odd tail padded
      add_rec.start   <= next_seq - 32'(cnt);
      add_rec.stop    <= next_seq;
      add_rec.length  <= cnt;
      add_rec.timer   <= 32'(RETRANSMIT_TICKS); // sent on the first visit
      add_rec.tries   <= '0;
    end
  end

endmodule

// File: rtl/tcpq_scanner.sv
// ==================================================
// tcpq scanner
// walks the packet records, frees acked packets,
// requests (re)transmission and raises force_fin
// ==================================================
module tcpq_scanner #(
  parameter int RETRANSMIT_TICKS = 1000000,
  parameter int RETRANSMIT_TRIES = 5,
  parameter int PACKET_DEPTH     = 3
) (
  input  logic                       clk,
  input  logic                       q_clr,
  input  logic [tcpq_pkg::SEQ_W-1:0] rem_ack,
  input  tcpq_pkg::pkt_info_t        upd_q,
  input  logic                       writing,
  output logic                       upd_we,
  output logic [PACKET_DEPTH-1:0]    upd_addr,
  output tcpq_pkg::pkt_info_t        upd_rec,
  output logic [PACKET_DEPTH:0]      free_ptr,
  output logic [tcpq_pkg::SEQ_W-1:0] release_ack,
  output logic                       tx_req,
  input  logic                       tx_ack,
  output logic [tcpq_pkg::SEQ_W-1:0] tx_seq,
  output logic [tcpq_pkg::LEN_W-1:0] tx_len,
  output logic [tcpq_pkg::CS_W-1:0]  tx_cs,
  output logic                       force_fin
);

  tcpq_pkg::scan_state_e      state;
  tcpq_pkg::pkt_info_t        rec;      // copy of the visited record
  logic [tcpq_pkg::SEQ_W-1:0] ack_diff; // stop - rem_ack, <= 0 means acked
  logic                       flushing; // clearing all records after q_clr
  logic                       free_it;
  logic                       send_it;

  always_ff @(posedge clk) begin
    if (q_clr) begin
      state       <= tcpq_pkg::scan_s;
      flushing    <= 1'b1;
      upd_addr    <= '0;
      upd_we      <= 1'b1;
      upd_rec     <= '0; // present cleared in every slot
      free_ptr    <= '0;
      release_ack <= rem_ack;
      free_it     <= 1'b0;
      send_it     <= 1'b0;
      tx_req      <= 1'b0;
      force_fin   <= 1'b0;
    end else if (flushing) begin
      upd_addr <= upd_addr + 1'b1;
      if (&upd_addr) begin
        flushing <= 1'b0;
        upd_we   <= 1'b0;
        state    <= tcpq_pkg::wait_s; // let upd_q catch up with slot 0
      end
    end else begin
      case (state)
        tcpq_pkg::scan_s: begin
          free_it <= 1'b0;
          send_it <= 1'b0;
          if (upd_q.present) begin
            rec      <= upd_q;
            ack_diff <= upd_q.stop - rem_ack;
            state    <= tcpq_pkg::read_s;
          end else begin
            state <= tcpq_pkg::next_s; // empty slot
          end
        end
        tcpq_pkg::read_s: begin
          // free strictly in order, so release_ack only moves forward
          free_it <= (ack_diff[tcpq_pkg::SEQ_W-1] || ack_diff == '0) &&
                     (upd_addr == free_ptr[PACKET_DEPTH-1:0]);
          send_it <= !ack_diff[tcpq_pkg::SEQ_W-1] && ack_diff != '0 &&
                     rec.timer == 32'(RETRANSMIT_TICKS);
          state   <= tcpq_pkg::check_s;
        end
        tcpq_pkg::check_s: begin
          // stay off the RAM while the packer adds, and wait for the last ack to drop
          if (!writing && !(send_it && tx_ack)) begin
            upd_we  <= 1'b1;
            upd_rec <= rec;
            state   <= tcpq_pkg::next_s;
            if (free_it) begin
              upd_rec.present <= 1'b0;
            end else if (send_it) begin
              upd_rec.timer <= '0;
              upd_rec.tries <= rec.tries + 1'b1;
              tx_req        <= 1'b1;
              tx_seq        <= rec.start;
              tx_len        <= rec.length;
              tx_cs         <= rec.chsum;
              if (32'(rec.tries) == RETRANSMIT_TRIES) force_fin <= 1'b1; // out of retries
              state         <= tcpq_pkg::send_s;
            end else if (rec.timer != 32'(RETRANSMIT_TICKS)) begin
              upd_rec.timer <= rec.timer + 1'b1; // one tick per visit, saturates
            end
          end
        end
        tcpq_pkg::send_s: begin
          upd_we <= 1'b0;
          if (tx_ack) begin
            tx_req <= 1'b0;
            state  <= tcpq_pkg::next_s;
          end
        end
        tcpq_pkg::next_s: begin
          upd_we   <= 1'b0;
          upd_addr <= upd_addr + 1'b1;
          if (free_it) begin
            free_ptr    <= free_ptr + 1'b1;
            release_ack <= rec.stop; // payload bytes up to here may be reused
          end
          state <= tcpq_pkg::wait_s;
        end
        tcpq_pkg::wait_s: state <= tcpq_pkg::scan_s;
        default:          state <= tcpq_pkg::scan_s;
      endcase
    end
  end

endmodule

// File: rtl/tcpq_top.sv
// ==================================================
// tcpq top
// tcp transmit queue: registers, payload and record
// RAMs, packer and scanner
// ==================================================
module tcpq_top #(
  parameter int MAX_PAYLOAD_LEN  = 1400,
  parameter int RETRANSMIT_TICKS = 1000000,
  parameter int RETRANSMIT_TRIES = 5,
  parameter int RAM_DEPTH        = 10,
  parameter int PACKET_DEPTH     = 3,
  parameter int WAIT_TICKS       = 20
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_we,
  input  tcpq_pkg::cfg_addr_e        cfg_addr,
  input  logic [31:0]                cfg_wdata,
  input  logic                       in_v,
  input  logic [7:0]                 in_d,
  input  logic                       snd,
  output logic                       cts,
  output logic                       tx_req,
  input  logic                       tx_ack,
  output logic [tcpq_pkg::SEQ_W-1:0] tx_seq,
  output logic [tcpq_pkg::LEN_W-1:0] tx_len,
  output logic [tcpq_pkg::CS_W-1:0]  tx_cs,
  input  logic [tcpq_pkg::SEQ_W-1:0] rd_addr,
  output logic [7:0]                 rd_data,
  output logic                       force_fin
);

  logic [tcpq_pkg::SEQ_W-1:0] isn, rem_ack, next_seq, release_ack;
  logic                       connected, q_clr, byte_v;
  logic                       data_full, slots_full, writing;
  logic                       add_we, upd_we;
  logic [PACKET_DEPTH-1:0]    add_addr, upd_addr;
  logic [PACKET_DEPTH:0]      free_ptr;
  tcpq_pkg::pkt_info_t        add_rec, upd_rec, upd_q;

  assign cts    = connected && !data_full && !slots_full;
  assign byte_v = in_v && cts; // bytes without cts are dropped

  tcpq_tcb_regs i_tcb (
    .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .isn, .rem_ack, .connected, .q_clr
  );

  tcpq_payload_ram #(.RAM_DEPTH(RAM_DEPTH)) i_payload (
    .clk, .q_clr, .isn, .wr_v(byte_v), .wr_d(in_d), .wr_seq(next_seq),
    .release_ack, .rd_addr, .rd_data, .data_full
  );

  tcpq_info_ram #(.PACKET_DEPTH(PACKET_DEPTH)) i_info (
    .clk, .add_we, .add_addr, .add_rec, .upd_we, .upd_addr, .upd_rec, .upd_q
  );

  tcpq_packer #(
    .MAX_PAYLOAD_LEN(MAX_PAYLOAD_LEN), .WAIT_TICKS(WAIT_TICKS),
    .RETRANSMIT_TICKS(RETRANSMIT_TICKS), .PACKET_DEPTH(PACKET_DEPTH)
  ) i_packer (
    .clk, .q_clr, .isn, .in_v(byte_v), .in_d, .snd, .data_full, .free_ptr,
    .add_we, .add_addr, .add_rec, .next_seq, .slots_full, .writing
  );

  tcpq_scanner #(
    .RETRANSMIT_TICKS(RETRANSMIT_TICKS), .RETRANSMIT_TRIES(RETRANSMIT_TRIES),
    .PACKET_DEPTH(PACKET_DEPTH)
  ) i_scanner (
    .clk, .q_clr, .rem_ack, .upd_q, .writing, .upd_we, .upd_addr, .upd_rec,
    .free_ptr, .release_ack, .tx_req, .tx_ack, .tx_seq, .tx_len, .tx_cs, .force_fin
  );

endmodule

// File: bench/tcpq_tb.sv
// ==================================================
// tcpq testbench
// streams packets into the transmit queue, plays the
// transmitter and checks requests, payload, force_fin
// ==================================================
module tcpq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LEN    = 8;
  localparam int RT_TICKS   = 200;
  localparam int RT_TRIES   = 2;
  localparam int RAM_DEPTH  = 6;
  localparam int PKT_DEPTH  = 2;
  localparam int WAIT_T     = 6;
  localparam int MODE_SND   = 0; // close with snd
  localparam int MODE_IDLE  = 1; // close by idle gap
  localparam int MODE_LEN   = 2; // long stream cut by length with an idle close at the tail
  localparam int N_ROWS     = 4;
  localparam int ROW_CYCLES = WAIT_T + RT_TICKS * (RT_TRIES + 1) * (2**PKT_DEPTH) * 8;
  localparam int QUIET      = RT_TICKS * (2**PKT_DEPTH) * 6; // beyond one retransmit period
  localparam logic [31:0] ISN_A = 32'hffff_ffe0; // wraps during the run
  localparam logic [31:0] ISN_B = 32'h4000_0100;

  // stimulus table of name, bytes, close mode and ack after first request
  string row_name  [N_ROWS] = '{"snd_close", "idle_close", "len_close", "retry"};
  int    row_bytes [N_ROWS] = '{5, 7, 2 * MAX_LEN + 3, 4};
  int    row_mode  [N_ROWS] = '{MODE_SND, MODE_IDLE, MODE_LEN, MODE_SND};
  bit    row_ack   [N_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0};

  logic                clk = 1'b0;
  logic                rst;
  logic                cfg_we;
  tcpq_pkg::cfg_addr_e cfg_addr;
  logic [31:0]         cfg_wdata;
  logic                in_v;
  logic [7:0]          in_d;
  logic                snd;
  logic                cts;
  logic                tx_req;
  logic                tx_ack;
  logic [31:0]         tx_seq;
  logic [15:0]         tx_len;
  logic [31:0]         tx_cs;
  logic [31:0]         rd_addr;
  logic [7:0]          rd_data;
  logic                force_fin;

  int          seed = 32'he31f;
  string       cur_name = "reset";
  bit          fin_held = 1'b0;          // force_fin stays high until a queue clear
  logic [31:0] tb_seq;                   // seq the DUT gives the next byte
  logic [7:0]  sent_bytes [bit [31:0]];  // every byte sent keyed by seq
  logic [31:0] exp_start [$];            // packets the close rules predict
  int          exp_len [$];
  logic [31:0] req_seq [$];              // requests seen by the transmitter
  logic [31:0] req_len [$];
  logic [31:0] req_cs [$];
  logic        req_fin [$];

  always #4 clk = ~clk;

  tcpq_top #(
    .MAX_PAYLOAD_LEN(MAX_LEN), .RETRANSMIT_TICKS(RT_TICKS), .RETRANSMIT_TRIES(RT_TRIES),
    .RAM_DEPTH(RAM_DEPTH), .PACKET_DEPTH(PKT_DEPTH), .WAIT_TICKS(WAIT_T)
  ) i_dut (
    .clk, .rst, .cfg_we, .cfg_addr, .cfg_wdata, .in_v, .in_d, .snd, .cts, .tx_req,
    .tx_ack, .tx_seq, .tx_len, .tx_cs, .rd_addr, .rd_data, .force_fin
  );

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error: %s %s expected %h actual %h", cur_name, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic cfg_write(input tcpq_pkg::cfg_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0; // single cycle write
  endtask

  task automatic connect(input logic [31:0] isn);
    cfg_write(tcpq_pkg::cfg_isn, isn);
    cfg_write(tcpq_pkg::cfg_rem_ack, isn); // nothing acked yet
    cfg_write(tcpq_pkg::cfg_ctrl, 32'd1);
    tb_seq = isn;
    while (!cts) @(negedge clk); // cts opens once connected
  endtask

  function automatic logic [31:0] expected_chsum(input logic [31:0] start, input int len);
    logic [31:0] sum;
    logic [7:0]  lo;
    sum = '0;
    for (int i = 0; i < len; i += 2) begin
      lo  = (i + 1 < len) ? sent_bytes[start + 32'(i + 1)] : 8'h00; // odd tail padded low
      sum = sum + {16'h0000, sent_bytes[start + 32'(i)], lo};      // big-endian pair
    end
    return sum;
  endfunction

  task automatic send_bytes(input int n, input int mode);
    int open_len;
    open_len = 0;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      in_v = 1'b0;
      while (!cts) @(negedge clk); // user side honours back-pressure
      in_v = 1'b1;
      in_d = 8'($random(seed));
      sent_bytes[tb_seq] = in_d;
      tb_seq = tb_seq + 32'd1;
      open_len++;
      if (open_len == MAX_LEN) begin // packer closes on length
        exp_start.push_back(tb_seq - 32'(MAX_LEN));
        exp_len.push_back(MAX_LEN);
        open_len = 0;
      end
    end
    @(negedge clk);
    in_v = 1'b0;
    if (open_len > 0) begin
      exp_start.push_back(tb_seq - 32'(open_len));
      exp_len.push_back(open_len);
      if (mode == MODE_SND) begin
        snd = 1'b1;
        @(negedge clk);
        snd = 1'b0;
      end // idle and length modes leave the tail to the idle timer
    end
  endtask

  // each predicted packet must be requested per_pkt times in any order
  task automatic check_requests(input int per_pkt, input bit retry);
    int hits;
    while (req_seq.size() < exp_start.size() * per_pkt) @(negedge clk);
    foreach (exp_start[j]) begin
      hits = 0;
      foreach (req_seq[r]) begin
        if (req_seq[r] == exp_start[j]) begin
          check_value("tx_len", 32'(exp_len[j]), req_len[r]);
          check_value("tx_cs", expected_chsum(exp_start[j], exp_len[j]), req_cs[r]);
          check_value("force_fin", 32'(fin_held || (retry && hits == RT_TRIES)),
                      32'(req_fin[r]));
          hits++;
        end
      end
      check_value("requests per packet", 32'(per_pkt), 32'(hits));
    end
    if (retry) fin_held = 1'b1; // last allowed retry raised force_fin
    exp_start.delete();
    exp_len.delete();
    req_seq.delete();
    req_len.delete();
    req_cs.delete();
    req_fin.delete();
  endtask

  task automatic quiet_window();
    repeat (QUIET) @(negedge clk);
    check_value("late requests", 32'd0, 32'(req_seq.size())); // freed or cleared packets
    check_value("tx_req", 32'd0, 32'(tx_req));
  endtask

  initial begin : transmitter
    logic [31:0] seq;
    logic [31:0] cs;
    logic        fin;
    int          len;
    tx_ack  = 1'b0;
    rd_addr = '0;
    forever begin
      @(negedge clk);
      if (tx_req && !tx_ack) begin
        seq     = tx_seq;
        len     = int'(tx_len);
        cs      = tx_cs;
        fin     = force_fin;
        rd_addr = seq;
        for (int i = 0; i < len; i++) begin
          @(negedge clk); // rd_data is valid a cycle after rd_addr
          check_value("payload byte", 32'(sent_bytes[seq + 32'(i)]), 32'(rd_data));
          rd_addr = seq + 32'(i + 1);
        end
        tx_ack = 1'b1;
        @(negedge clk);
        while (tx_req) @(negedge clk);
        tx_ack = 1'b0; // four-phase done
        req_seq.push_back(seq);
        req_len.push_back(32'(len));
        req_cs.push_back(cs);
        req_fin.push_back(fin);
      end
    end
  end

  initial begin : watchdog
    int limit;
    limit = 2 * ROW_CYCLES + 100; // slot fill and reconnect tests plus reset
    for (int r = 0; r < N_ROWS; r++) limit += row_bytes[r] + ROW_CYCLES;
    repeat (limit) @(posedge clk);
    $display("timeout: the queue did not finish the tests within %0d cycles", limit);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin : main
    rst       = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = tcpq_pkg::cfg_isn;
    cfg_wdata = '0;
    in_v      = 1'b0;
    in_d      = '0;
    snd       = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("cts", 32'd0, 32'(cts)); // connection still down
    check_value("tx_req", 32'd0, 32'(tx_req));
    check_value("force_fin", 32'd0, 32'(force_fin));
    connect(ISN_A);

    cur_name = "slot_fill"; // every record slot taken without acks
    repeat (2**PKT_DEPTH) send_bytes(1, MODE_SND);
    check_requests(1, 1'b0);
    check_value("cts", 32'd0, 32'(cts));
    cfg_write(tcpq_pkg::cfg_rem_ack, tb_seq);
    while (!cts) @(negedge clk); // covering ack frees slots
    quiet_window();

    for (int r = 0; r < N_ROWS; r++) begin
      cur_name = row_name[r];
      send_bytes(row_bytes[r], row_mode[r]);
      check_requests(row_ack[r] ? 1 : RT_TRIES + 1, !row_ack[r]);
      cfg_write(tcpq_pkg::cfg_rem_ack, tb_seq); // covers all sent bytes
      quiet_window();
    end

    cur_name = "reconnect";
    send_bytes(3, MODE_SND); // left unacked across the drop
    check_requests(1, 1'b0);
    cfg_write(tcpq_pkg::cfg_ctrl, 32'd0);
    repeat (2) @(negedge clk); // connected drops and the queue clears
    check_value("cts", 32'd0, 32'(cts));
    check_value("tx_req", 32'd0, 32'(tx_req));
    check_value("force_fin", 32'd0, 32'(force_fin));
    fin_held = 1'b0;
    quiet_window();
    connect(ISN_B);
    send_bytes(6, MODE_SND);
    check_requests(1, 1'b0);
    cfg_write(tcpq_pkg::cfg_rem_ack, tb_seq);
    quiet_window();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: compile.f
rtl/tcpq_pkg.sv
rtl/tcpq_tcb_regs.sv
rtl/tcpq_payload_ram.sv
rtl/tcpq_info_ram.sv
rtl/tcpq_packer.sv
rtl/tcpq_scanner.sv
rtl/tcpq_top.sv
bench/tcpq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tcpq_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
